// File: Makefile
TOOL       = verilator
FLAGS      = --binary --timing --assert --timescale 1ns/10ps -j 0
LINT_FLAGS = --lint-only -Wall --timing --timescale 1ns/10ps
TOP        = prot_tb
FILELIST   = list.f
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = === FAIL ===
PASS_MSG   = === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -qF "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a result"; exit 1; }

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: list.f
source/prot_map_pkg.sv
source/prot_game_pkg.sv
source/prot_bus_if.sv
source/prot_decode.sv
source/prot_storage.sv
source/prot_irq.sv
source/prot_read_path.sv
source/prot_top.sv
tb/prot_chk.sv
tb/prot_tb.sv

// File: source/prot_bus_if.sv
`timescale 1ns/10ps

interface prot_bus_if;

    // MCU address, 2 MB space
    logic [prot_map_pkg::mcu_addr_w-1:0] addr;
    // MCU write data
    logic [7:0] dout;
    // strobes, active low, valid from sx
    logic wrn;
    logic rdn;
    // address strobe, opens the bus cycle
    logic sx;
    // cycle end, closes it
    logic ce;
    // board variant selects the address map
    prot_game_pkg::game_e game;

    modport decode (
        input addr, dout, wrn, rdn, sx, ce, game
    );

    modport storage (
        input addr, dout, wrn
    );

    modport read_path (
        input ce
    );

endinterface

// File: source/prot_decode.sv
`timescale 1ns/10ps

module prot_decode (
    input  logic                       clk,
    input  logic                       rst,
    prot_bus_if.decode                 bus,
    output logic                       rom_cs,
    output logic                       work_cs,
    output logic                       shd_cs,
    output logic                       prot_cs,
    output logic                       bac_cs,
    output logic                       bac_mode,
    output logic [10:0]                bac_addr,
    output logic [1:0]                 bac_dsn,
    output prot_map_pkg::prot_region_e region
);

    prot_map_pkg::prot_region_e nxt_region;
    logic [10:0]                nxt_bac_addr;
    logic [1:0]                 nxt_bac_dsn;
    logic                       bac_area;
    logic                       access;

    // a real bus cycle has one of the strobes low together with sx
    assign access   = ~bus.rdn | ~bus.wrn;
    // 1a0000-1bffff, video chip window on hippodrome
    assign bac_area = bus.addr[20:17] == 4'b1101;

    always_comb begin
        nxt_region   = prot_map_pkg::region_none;
        nxt_bac_addr = '0;
        nxt_bac_dsn  = 2'b11;
        if (bus.game == prot_game_pkg::hippodrome) begin
            if (bus.addr[20:16] == 5'h00) begin
                nxt_region = prot_map_pkg::region_rom;
            end else if (bus.addr[20:16] == 5'h1f) begin
                nxt_region = prot_map_pkg::region_work_ram;
            end else if (bus.addr[20:17] == 4'b1100) begin
                // 180000-19ffff
                nxt_region = prot_map_pkg::region_shared_ram;
            end else if (bus.addr[20:17] == 4'b1110) begin
                // 1c0000-1dffff, protection chip
                nxt_region = prot_map_pkg::region_prot;
            end else if (bac_area) begin
                // a12:a11 picks mode reg, scroll ram or map ram
                case (bus.addr[12:11])
                    2'd0:    nxt_region = prot_map_pkg::region_bac_mode;
                    2'd1:    nxt_region = prot_map_pkg::region_bac_ram;
                    2'd2:    nxt_region = prot_map_pkg::region_bac_ram;
                    default: nxt_region = prot_map_pkg::region_none;
                endcase
            end
            if (bac_area) begin
                // map ram sits in the upper half of the chip space
                nxt_bac_addr = {bus.addr[12:11] == 2'd2, bus.addr[10:1]};
                // 16-bit chip, odd address is the low byte
                nxt_bac_dsn  = {~bus.addr[0], bus.addr[0]};
            end
        end else begin
            if (bus.addr[20:16] == 5'h00) begin
                nxt_region = prot_map_pkg::region_rom;
            end else if (bus.addr[20:16] == 5'h1f) begin
                // 1f0000-1f1fff work, 1f2000-1f3fff shared
                nxt_region = bus.addr[13] ? prot_map_pkg::region_shared_ram
                                          : prot_map_pkg::region_work_ram;
            end
        end
    end

    // selects latch on sx and hold until ce
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            region   <= prot_map_pkg::region_none;
            rom_cs   <= 1'b0;
            work_cs  <= 1'b0;
            shd_cs   <= 1'b0;
            prot_cs  <= 1'b0;
            bac_cs   <= 1'b0;
            bac_mode <= 1'b0;
            bac_addr <= '0;
            bac_dsn  <= 2'b11;
        end else if (bus.sx && access) begin
            region   <= nxt_region;
            rom_cs   <= nxt_region == prot_map_pkg::region_rom;
            work_cs  <= nxt_region == prot_map_pkg::region_work_ram;
            shd_cs   <= nxt_region == prot_map_pkg::region_shared_ram;
            prot_cs  <= nxt_region == prot_map_pkg::region_prot;
            bac_cs   <= nxt_region == prot_map_pkg::region_bac_ram;
            bac_mode <= nxt_region == prot_map_pkg::region_bac_mode;
            bac_addr <= nxt_bac_addr;
            bac_dsn  <= nxt_bac_dsn;
        end else if (bus.ce) begin
            // ce only comes once waitn is high again
            region   <= prot_map_pkg::region_none;
            rom_cs   <= 1'b0;
            work_cs  <= 1'b0;
            shd_cs   <= 1'b0;
            prot_cs  <= 1'b0;
            bac_cs   <= 1'b0;
            bac_mode <= 1'b0;
            bac_addr <= '0;
            bac_dsn  <= 2'b11;
        end
    end

endmodule

// File: source/prot_game_pkg.sv
package prot_game_pkg;

    // board variants sharing this protection logic
    typedef enum logic {
        robocop    = 1'b0,
        hippodrome = 1'b1
    } game_e;

    // hippodrome protection chip, only two known key/answer pairs
    localparam logic [7:0] prot_key_a = 8'h45;
    localparam logic [7:0] prot_ans_a = 8'h4e;

    localparam logic [7:0] prot_key_b = 8'h92;
    localparam logic [7:0] prot_ans_b = 8'h15;

    // irq1 hold time in clk cycles after the main CPU trigger
    localparam logic [7:0] irq_hold = 8'd255;

endpackage

// File: source/prot_irq.sv
`timescale 1ns/10ps

module prot_irq (
    input  logic                                 clk,
    input  logic                                 rst,
    input  prot_game_pkg::game_e                 game,
    input  logic                                 main_cs,
    input  logic [prot_map_pkg::main_addr_w-1:0] main_addr,
    input  logic                                 lvbl,
    output logic                                 irq1_n,
    output logic                                 irq2_n
);

    logic       set_irq;
    logic       set_irq_l;
    logic       set_pulse;
    logic [7:0] cnt;
    logic [7:0] cnt_nxt;
    logic       irq1;

    // robocop raises irq1 when the main cpu touches the last shared byte
    assign set_irq   = main_cs && main_addr == '1 && game == prot_game_pkg::robocop;
    // one load per access, even if main_cs stays high
    assign set_pulse = set_irq & ~set_irq_l;
    assign cnt_nxt   = set_pulse ? prot_game_pkg::irq_hold :
                       (cnt != 8'd0) ? cnt - 8'd1 : cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            set_irq_l <= 1'b0;
            cnt       <= 8'd0;
            irq1      <= 1'b0;
        end else begin
            set_irq_l <= set_irq;
            cnt       <= cnt_nxt;
            if (set_pulse) begin
                irq1 <= 1'b1;
            end else if (cnt_nxt == 8'd1) begin
                // released as the count lands on 1
                irq1 <= 1'b0;
            end
        end
    end

    assign irq1_n = ~irq1;
    // hippodrome takes irq2 straight from vertical blank
    assign irq2_n = !(game == prot_game_pkg::hippodrome && !lvbl);

endmodule

// File: source/prot_map_pkg.sv
package prot_map_pkg;

    // full address bus of the protection MCU
    localparam int mcu_addr_w = 21;

    // main CPU sees 2 kB of the shared RAM, byte lanes as words
    localparam int main_addr_w = 11;

    // MCU side of the shared RAM, 8 kB
    localparam int shared_aw = 13;

    // local work RAM, 2 kB
    localparam int work_aw = 11;

    // one entry per chip select the decoder can latch
    typedef enum logic [2:0] {
        region_none       = 3'd0,
        region_rom        = 3'd1,
        region_work_ram   = 3'd2,
        region_shared_ram = 3'd3,
        region_prot       = 3'd4,
        // video chip tile/scroll memory
        region_bac_ram    = 3'd5,
        // video chip mode register read
        region_bac_mode   = 3'd6
    } prot_region_e;

endpackage

// File: source/prot_read_path.sv
`timescale 1ns/10ps

module prot_read_path (
    input  logic                       clk,
    input  logic                       rst,
    prot_bus_if.read_path              bus,
    input  prot_map_pkg::prot_region_e region,
    input  logic [7:0]                 work_q,
    input  logic [7:0]                 shd_q,
    input  logic [7:0]                 prot_q,
    input  logic [7:0]                 rom_data,
    input  logic                       rom_cs,
    input  logic                       rom_ok,
    input  logic [7:0]                 bac_data,
    input  logic                       bac_cs,
    input  logic                       bac_ok,
    input  logic [7:0]                 bac_mode_din,
    input  logic                       main_cs,
    output logic [7:0]                 din,
    output logic                       waitn
);

    logic       rom_good;
    logic       bac_good;
    logic [7:0] din_nxt;

    // a port is good when idle or once it has answered
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_good <= 1'b1;
            bac_good <= 1'b1;
        end else begin
            rom_good <= !rom_cs || rom_ok;
            bac_good <= !bac_cs || bac_ok;
        end
    end

    // main cpu access to the shared ram stalls the mcu
    assign waitn = ~main_cs & rom_good & bac_good;

    always_comb begin
        case (region)
            prot_map_pkg::region_rom:        din_nxt = rom_data;
            prot_map_pkg::region_work_ram:   din_nxt = work_q;
            prot_map_pkg::region_shared_ram: din_nxt = shd_q;
            prot_map_pkg::region_prot:       din_nxt = prot_q;
            prot_map_pkg::region_bac_ram:    din_nxt = bac_data;
            prot_map_pkg::region_bac_mode:   din_nxt = bac_mode_din;
            // open bus
            default:                         din_nxt = 8'hff;
        endcase
    end

    // held on ce so the core samples a stable byte at cycle end
    always_ff @(posedge clk) begin
        if (!bus.ce) begin
            din <= din_nxt;
        end
    end

endmodule

// File: source/prot_storage.sv
`timescale 1ns/10ps

module prot_storage #(
    parameter int SHARED_AW = 13,
    parameter int WORK_AW   = 11
) (
    input  logic                                 clk,
    input  logic                                 rst,
    prot_bus_if.storage                          bus,
    input  logic                                 work_cs,
    input  logic                                 shd_cs,
    input  logic                                 prot_cs,
    input  logic                                 main_cs,
    input  logic                                 main_wrn,
    input  logic [prot_map_pkg::main_addr_w-1:0] main_addr,
    input  logic [7:0]                           main_dout,
    output logic [7:0]                           main_din,
    output logic [7:0]                           work_q,
    output logic [7:0]                           shd_q,
    output logic [7:0]                           prot_q
);

    logic [7:0]           work_mem [2**WORK_AW];
    logic [7:0]           shd_mem  [2**SHARED_AW];
    logic [SHARED_AW-1:0] main_word;
    logic [SHARED_AW-1:0] mcu_shd_addr;
    logic                 work_we;
    logic                 shd_we;
    logic                 main_we;
    logic [7:0]           prot_st;

    assign work_we      = work_cs & ~bus.wrn;
    assign shd_we       = shd_cs & ~bus.wrn;
    assign main_we      = main_cs & ~main_wrn;
    // main cpu only reaches the bottom 2 kB, top address bits stay zero
    assign main_word    = SHARED_AW'(main_addr);
    assign mcu_shd_addr = bus.addr[SHARED_AW-1:0];

    // work ram, synchronous read
    always_ff @(posedge clk) begin
        if (work_we) begin
            work_mem[bus.addr[WORK_AW-1:0]] <= bus.dout;
        end
        work_q <= work_mem[bus.addr[WORK_AW-1:0]];
    end

    // shared ram, main port and mcu port on the same clock
    always_ff @(posedge clk) begin
        if (main_we) begin
            shd_mem[main_word] <= main_dout;
        end
        if (shd_we) begin
            shd_mem[mcu_shd_addr] <= bus.dout;
        end
        main_din <= shd_mem[main_word];
        shd_q    <= shd_mem[mcu_shd_addr];
    end

    // protection latch keeps the last key written by the mcu
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prot_st <= 8'h00;
        end else if (prot_cs && !bus.wrn) begin
            prot_st <= bus.dout;
        end
    end

    // lookup of the answer, unknown keys give zero
    always_comb begin
        case (prot_st)
            prot_game_pkg::prot_key_a: prot_q = prot_game_pkg::prot_ans_a;
            prot_game_pkg::prot_key_b: prot_q = prot_game_pkg::prot_ans_b;
            default:                   prot_q = 8'h00;
        endcase
    end

endmodule

// File: source/prot_top.sv
`timescale 1ns/10ps

module prot_top (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 lvbl,
    input  prot_game_pkg::game_e                 game,
    // microcontroller core bus
    input  logic [prot_map_pkg::mcu_addr_w-1:0]  mcu_addr,
    input  logic [7:0]                           mcu_dout,
    input  logic                                 mcu_wrn,
    input  logic                                 mcu_rdn,
    input  logic                                 mcu_sx,
    input  logic                                 mcu_ce,
    output logic [7:0]                           mcu_din,
    output logic                                 waitn,
    output logic                                 irq1_n,
    output logic                                 irq2_n,
    // main cpu window onto the shared ram
    input  logic                                 main_cs,
    input  logic                                 main_wrn,
    input  logic [prot_map_pkg::main_addr_w-1:0] main_addr,
    input  logic [7:0]                           main_dout,
    output logic [7:0]                           main_din,
    // program rom
    output logic [15:0]                          rom_addr,
    output logic                                 rom_cs,
    input  logic [7:0]                           rom_data,
    input  logic                                 rom_ok,
    // video chip, hippodrome only
    output logic                                 bac_cs,
    output logic                                 bac_mode,
    output logic [10:0]                          bac_addr,
    output logic [1:0]                           bac_dsn,
    output logic                                 bac_rnw,
    output logic [7:0]                           bac_dout,
    input  logic [7:0]                           bac_data,
    input  logic [7:0]                           bac_mode_din,
    input  logic                                 bac_ok
);

    prot_bus_if bus ();

    prot_map_pkg::prot_region_e region;
    logic                       work_cs;
    logic                       shd_cs;
    logic                       prot_cs;
    logic [7:0]                 work_q;
    logic [7:0]                 shd_q;
    logic [7:0]                 prot_q;

    assign bus.addr = mcu_addr;
    assign bus.dout = mcu_dout;
    assign bus.wrn  = mcu_wrn;
    assign bus.rdn  = mcu_rdn;
    assign bus.sx   = mcu_sx;
    assign bus.ce   = mcu_ce;
    assign bus.game = game;

    // rom is 64 kB, video chip takes the mcu write data as is
    assign rom_addr = mcu_addr[15:0];
    assign bac_rnw  = mcu_wrn;
    assign bac_dout = mcu_dout;

    prot_decode u_decode (
        .clk(clk), .rst(rst), .bus(bus.decode),
        .rom_cs(rom_cs), .work_cs(work_cs), .shd_cs(shd_cs), .prot_cs(prot_cs),
        .bac_cs(bac_cs), .bac_mode(bac_mode), .bac_addr(bac_addr),
        .bac_dsn(bac_dsn), .region(region)
    );

    prot_storage #(
        .SHARED_AW(prot_map_pkg::shared_aw),
        .WORK_AW  (prot_map_pkg::work_aw)
    ) u_storage (
        .clk(clk), .rst(rst), .bus(bus.storage),
        .work_cs(work_cs), .shd_cs(shd_cs), .prot_cs(prot_cs),
        .main_cs(main_cs), .main_wrn(main_wrn), .main_addr(main_addr),
        .main_dout(main_dout), .main_din(main_din),
        .work_q(work_q), .shd_q(shd_q), .prot_q(prot_q)
    );

    prot_irq u_irq (
        .clk(clk), .rst(rst), .game(game), .main_cs(main_cs),
        .main_addr(main_addr), .lvbl(lvbl), .irq1_n(irq1_n), .irq2_n(irq2_n)
    );

    prot_read_path u_read_path (
        .clk(clk), .rst(rst), .bus(bus.read_path), .region(region),
        .work_q(work_q), .shd_q(shd_q), .prot_q(prot_q),
        .rom_data(rom_data), .rom_cs(rom_cs), .rom_ok(rom_ok),
        .bac_data(bac_data), .bac_cs(bac_cs), .bac_ok(bac_ok),
        .bac_mode_din(bac_mode_din), .main_cs(main_cs),
        .din(mcu_din), .waitn(waitn)
    );

endmodule

// File: tb/prot_chk.sv
`timescale 1ns/10ps

module prot_chk (
    input logic clk,
    input logic rst,
    input logic rom_cs,
    input logic work_cs,
    input logic shd_cs,
    input logic prot_cs,
    input logic bac_cs,
    input logic bac_mode,
    input logic mcu_ce,
    input logic waitn,
    input logic irq1_n
);

    // length of the current irq1 pulse, saturating
    logic [8:0] irq1_low;
    logic [5:0] sels;

    assign sels = {rom_cs, work_cs, shd_cs, prot_cs, bac_cs, bac_mode};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            irq1_low <= 9'd0;
        end else if (irq1_n) begin
            irq1_low <= 9'd0;
        end else if (irq1_low != 9'h1ff) begin
            irq1_low <= irq1_low + 9'd1;
        end
    end

    // at most one region selected, and nothing left selected once ce has closed the cycle
    sel_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(sels) && (!$past(mcu_ce) || sels == 6'd0))
        else $error("chip selects not one-hot or still active after ce");

    // core may only end a cycle once the board lets it
    ce_waitn: assert property (@(posedge clk) disable iff (rst) mcu_ce |-> waitn)
        else $error("ce asserted while waitn is low");

    irq1_release: assert property (@(posedge clk) disable iff (rst) irq1_low <= 9'd260)
        else $error("irq1_n held low for more than 260 cycles");

endmodule

bind prot_top prot_chk u_chk (
    .clk(clk), .rst(rst),
    .rom_cs(rom_cs), .work_cs(work_cs), .shd_cs(shd_cs), .prot_cs(prot_cs),
    .bac_cs(bac_cs), .bac_mode(bac_mode),
    .mcu_ce(mcu_ce), .waitn(waitn), .irq1_n(irq1_n)
);

// File: tb/prot_tb.sv
`timescale 1ns/10ps

module prot_tb;

    // cycles of run time allowed per line of test data
    localparam int op_budget = 400;

    logic                                 clk;
    logic                                 rst;
    logic                                 lvbl;
    prot_game_pkg::game_e                 game;
    logic [prot_map_pkg::mcu_addr_w-1:0]  mcu_addr;
    logic [7:0]                           mcu_dout;
    logic                                 mcu_wrn;
    logic                                 mcu_rdn;
    logic                                 mcu_sx;
    logic                                 mcu_ce;
    logic [7:0]                           mcu_din;
    logic                                 waitn;
    logic                                 irq1_n;
    logic                                 irq2_n;
    logic                                 main_cs;
    logic                                 main_wrn;
    logic [prot_map_pkg::main_addr_w-1:0] main_addr;
    logic [7:0]                           main_dout;
    logic [7:0]                           main_din;
    logic [15:0]                          rom_addr;
    logic                                 rom_cs;
    logic [7:0]                           rom_data;
    logic                                 rom_ok;
    logic                                 bac_cs;
    logic                                 bac_mode;
    logic [10:0]                          bac_addr;
    logic [1:0]                           bac_dsn;
    logic                                 bac_rnw;
    logic [7:0]                           bac_dout;
    logic [7:0]                           bac_data;
    logic [7:0]                           bac_mode_din;
    logic                                 bac_ok;

    // one entry per line of test data
    string       op_q[$];
    string       game_q[$];
    logic [20:0] addr_q[$];
    logic [7:0]  data_q[$];
    logic [7:0]  exp_q[$];
    int          op_count;
    bit          load_done;
    int          errors;
    int          checks;
    logic [31:0] lfsr_state;
    // contents of the video chip mode register
    logic [7:0]  mode_value;

    prot_top uut (
        .clk(clk), .rst(rst), .lvbl(lvbl), .game(game),
        .mcu_addr(mcu_addr), .mcu_dout(mcu_dout), .mcu_wrn(mcu_wrn), .mcu_rdn(mcu_rdn),
        .mcu_sx(mcu_sx), .mcu_ce(mcu_ce), .mcu_din(mcu_din), .waitn(waitn),
        .irq1_n(irq1_n), .irq2_n(irq2_n),
        .main_cs(main_cs), .main_wrn(main_wrn), .main_addr(main_addr),
        .main_dout(main_dout), .main_din(main_din),
        .rom_addr(rom_addr), .rom_cs(rom_cs), .rom_data(rom_data), .rom_ok(rom_ok),
        .bac_cs(bac_cs), .bac_mode(bac_mode), .bac_addr(bac_addr), .bac_dsn(bac_dsn),
        .bac_rnw(bac_rnw), .bac_dout(bac_dout), .bac_data(bac_data),
        .bac_mode_din(bac_mode_din), .bac_ok(bac_ok)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1, new bit shifted in at the bottom
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // 0 to 3 cycles, one lfsr step per bit
    task automatic draw_delay(output int d);
        logic [1:0] bits;
        int         k;
        bits = 2'b00;
        for (k = 0; k < 2; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[0], lfsr_state[0]};
        end
        d = int'(bits);
    endtask

    // rom model, data only shows up together with ok
    initial begin
        int rom_wait;
        rom_wait = -1;
        rom_ok   = 1'b0;
        rom_data = 8'h00;
        forever begin
            @(posedge clk);
            #1;
            if (!rom_cs) begin
                rom_ok   = 1'b0;
                rom_wait = -1;
            end else if (rom_wait < 0) begin
                draw_delay(rom_wait);
                rom_ok = (rom_wait == 0);
            end else if (rom_wait > 0) begin
                rom_wait--;
                rom_ok = (rom_wait == 0);
            end
            rom_data = rom_ok ? (rom_addr[7:0] ^ rom_addr[15:8]) : 8'h00;
        end
    end

    // video chip model, same delay scheme as the rom
    initial begin
        int bac_wait;
        bac_wait = -1;
        bac_ok   = 1'b0;
        bac_data = 8'h00;
        forever begin
            @(posedge clk);
            #1;
            if (!bac_cs) begin
                bac_ok   = 1'b0;
                bac_wait = -1;
            end else if (bac_wait < 0) begin
                draw_delay(bac_wait);
                bac_ok = (bac_wait == 0);
            end else if (bac_wait > 0) begin
                bac_wait--;
                bac_ok = (bac_wait == 0);
            end
            bac_data = bac_ok ? ~bac_addr[7:0] : 8'h00;
            // chip bus carries the core strobe and data, odd byte on the low strobe
            if (bac_cs) begin
                checks++;
                if (bac_rnw !== ~mcu_rdn || bac_dout !== mcu_dout
                    || bac_dsn !== (mcu_addr[0] ? 2'b01 : 2'b10)) begin
                    errors++;
                    $display("** Error at %0t ns: bac bus rnw %b dout %h dsn %b for address %h",
                             $time, bac_rnw, bac_dout, bac_dsn, mcu_addr);
                end
            end
        end
    end

    // mode register only drives its byte while the chip selects it
    initial begin
        bac_mode_din = 8'h00;
        forever begin
            @(posedge clk);
            #1;
            bac_mode_din = bac_mode ? mode_value : 8'h00;
        end
    end

    task automatic load_testdata();
        int          fd;
        int          n;
        string       line;
        string       op;
        string       gname;
        logic [20:0] a;
        logic [7:0]  d;
        logic [7:0]  e;
        fd = $fopen("tb/prot_testdata.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open tb/prot_testdata.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                // lines starting with # are notes
                if (n > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %s %h %h %h", op, gname, a, d, e);
                    if (n == 5) begin
                        op_q.push_back(op);
                        game_q.push_back(gname);
                        addr_q.push_back(a);
                        data_q.push_back(d);
                        exp_q.push_back(e);
                    end
                end
            end
            $fclose(fd);
        end
        op_count = op_q.size();
        if (op_count == 0) begin
            errors++;
            $display("no operations found in the test data");
        end
        load_done = 1'b1;
    endtask

    // one core bus cycle: sx, wait for waitn, then ce
    task automatic mcu_access(input logic [20:0] addr, input logic write,
                              input logic [7:0] wdata, output logic [7:0] rdata);
        int guard;
        @(posedge clk);
        #1;
        mcu_addr = addr;
        mcu_dout = wdata;
        mcu_wrn  = !write;
        mcu_rdn  = write;
        mcu_sx   = 1'b1;
        @(posedge clk);
        #1;
        mcu_sx = 1'b0;
        // good flags settle one cycle after the selects
        @(posedge clk);
        #1;
        guard = 0;
        while (!waitn && guard < 50) begin
            @(posedge clk);
            #1;
            guard++;
        end
        if (!waitn) begin
            errors++;
            $display("waitn never came back for mcu address %h", addr);
        end
        mcu_ce = 1'b1;
        @(posedge clk);
        #1;
        rdata   = mcu_din;
        mcu_ce  = 1'b0;
        mcu_wrn = 1'b1;
        mcu_rdn = 1'b1;
    endtask

    task automatic main_write(input logic [10:0] addr, input logic [7:0] data);
        @(posedge clk);
        #1;
        main_cs   = 1'b1;
        main_wrn  = 1'b0;
        main_addr = addr;
        main_dout = data;
        @(posedge clk);
        #1;
        main_cs  = 1'b0;
        main_wrn = 1'b1;
    endtask

    // main cpu read, also watches waitn while main_cs is held
    task automatic main_read(input logic [10:0] addr, input logic [7:0] want);
        logic [7:0] got;
        logic       wait_seen;
        int         k;
        @(posedge clk);
        #1;
        main_cs   = 1'b1;
        main_wrn  = 1'b1;
        main_addr = addr;
        wait_seen = 1'b0;
        got       = 8'h00;
        for (k = 0; k < 3; k++) begin
            @(posedge clk);
            #1;
            if (k == 0) begin
                got = main_din;
            end
            wait_seen = wait_seen | waitn;
        end
        main_cs = 1'b0;
        @(posedge clk);
        #1;
        checks += 3;
        if (got !== want) begin
            errors++;
            $display("** Error at %0t ns: main read %h gave %h, expected %h",
                     $time, addr, got, want);
        end
        if (wait_seen !== 1'b0) begin
            errors++;
            $display("** Error at %0t ns: waitn went high while main_cs was held", $time);
        end
        if (waitn !== 1'b1) begin
            errors++;
            $display("** Error at %0t ns: waitn low after main_cs dropped", $time);
        end
    endtask

    // counts the cycles irq1_n stays low after a main access
    task automatic irq1_check(input logic [10:0] addr, input logic [7:0] want);
        int n;
        @(posedge clk);
        #1;
        main_cs   = 1'b1;
        main_wrn  = 1'b1;
        main_addr = addr;
        @(posedge clk);
        #1;
        main_cs = 1'b0;
        n = 0;
        while (!irq1_n && n < 300) begin
            @(posedge clk);
            #1;
            n++;
        end
        checks++;
        if (n != int'(want)) begin
            errors++;
            $display("** Error at %0t ns: irq1_n low for %0d cycles, expected %0d",
                     $time, n, int'(want));
        end
    endtask

    task automatic run_op(input int i);
        logic [7:0] got;
        game = (game_q[i] == "hippodrome") ? prot_game_pkg::hippodrome
                                           : prot_game_pkg::robocop;
        if (op_q[i] == "mw") begin
            main_write(addr_q[i][10:0], data_q[i]);
        end else if (op_q[i] == "mr") begin
            main_read(addr_q[i][10:0], exp_q[i]);
        end else if (op_q[i] == "cw") begin
            mcu_access(addr_q[i], 1'b1, data_q[i], got);
        end else if (op_q[i] == "cr") begin
            // data column feeds the video chip mode register
            mode_value = data_q[i];
            // core leaves a stray byte on its data bus during reads
            mcu_access(addr_q[i], 1'b0, 8'h5c, got);
            checks++;
            if (got !== exp_q[i]) begin
                errors++;
                $display("** Error at %0t ns: mcu read %h gave %h, expected %h",
                         $time, addr_q[i], got, exp_q[i]);
            end
        end else if (op_q[i] == "irq") begin
            irq1_check(addr_q[i][10:0], exp_q[i]);
        end else if (op_q[i] == "blank") begin
            lvbl = data_q[i][0];
            @(posedge clk);
            #1;
            checks++;
            if (irq2_n !== exp_q[i][0]) begin
                errors++;
                $display("** Error at %0t ns: irq2_n is %b with lvbl %b, expected %b",
                         $time, irq2_n, lvbl, exp_q[i][0]);
            end
        end else begin
            errors++;
            $display("unknown operation %s on test data entry %0d", op_q[i], i);
        end
    endtask

    initial begin
        int i;
        rst          = 1'b1;
        lvbl         = 1'b1;
        game         = prot_game_pkg::robocop;
        mcu_addr     = '0;
        mcu_dout     = 8'h00;
        mcu_wrn      = 1'b1;
        mcu_rdn      = 1'b1;
        mcu_sx       = 1'b0;
        mcu_ce       = 1'b0;
        main_cs      = 1'b0;
        main_wrn     = 1'b1;
        main_addr    = '0;
        main_dout    = 8'h00;
        mode_value   = 8'h00;
        errors       = 0;
        checks       = 0;
        lfsr_state   = 32'he19de2ee;
        load_testdata();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        for (i = 0; i < op_count; i++) begin
            run_op(i);
        end
        $display("operations %0d, checks %0d, errors %0d", op_count, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // budget grows with the number of operations
    initial begin
        wait (load_done);
        repeat ((op_count + 1) * op_budget) @(posedge clk);
        $display("watchdog expired, the test did not finish in time");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: tb/prot_testdata.txt
# op game addr data expect, hex fields; mw/mr/irq take the main cpu word address
# ops: mw/mr main cpu, cw/cr mcu bus (cr data drives bac_mode_din), irq trigger, blank lvbl
mw robocop 000123 a5 00
cr robocop 1f2123 00 a5
cw robocop 1f2456 3c 00
mr robocop 000456 00 3c
mw hippodrome 000321 5e 00
cr hippodrome 180321 00 5e
cw hippodrome 180654 c7 00
mr hippodrome 000654 00 c7
cr hippodrome 19e123 00 a5
cw robocop 1f0012 77 00
cr robocop 1f0012 00 77
cw hippodrome 1f4321 e8 00
cr hippodrome 1f4321 00 e8
cr robocop 100000 00 ff
cw hippodrome 1c0000 45 00
cr hippodrome 1c0000 00 4e
cw hippodrome 1c0000 92 00
cr hippodrome 1c0000 00 15
cw hippodrome 1c0000 33 00
cr hippodrome 1c0000 00 00
cr robocop 1c0000 00 ff
cr robocop 001234 00 26
cr robocop 00beef 00 51
cr hippodrome 00a5c3 00 66
cr hippodrome 007f01 00 7e
irq robocop 0007ff 00 fe
irq hippodrome 0007ff 00 00
blank hippodrome 000000 00 00
blank hippodrome 000000 01 01
blank robocop 000000 00 01
cr hippodrome 1a0a46 00 dc
cr hippodrome 1b1234 00 e5
cr hippodrome 1a0000 5a 5a
cr hippodrome 1b9800 00 ff
